// ==== rtl/uartFramePkg.sv ====
package uartFramePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame format: 1 start bit, 8 data bits LSB first, 1 stop bit.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DataBits = 8;                // Data bits per frame.

    typedef logic [DataBits-1:0] uartByte_t;

    // Clocks per bit, truncated to a whole number of cycles.
    function automatic logic [31:0] bitPeriod(
        input int unsigned clkFreqMhz,
        input int unsigned baudRate
    );
        longint unsigned clkHz;
        clkHz = longint'(clkFreqMhz) * 64'd1000000;
        return 32'(clkHz / baudRate);
    endfunction

endpackage

// ==== rtl/uartRx.sv ====
module uartRx #(
    parameter int unsigned ClkFreqMhz = 27,
    parameter int unsigned BaudRate   = 115200
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rxd,
    output uartFramePkg::uartByte_t rxData,
    output logic                    rxValid,
    output logic                    frameError
);

    import uartFramePkg::*;
    import uartStatePkg::*;

    localparam logic [31:0] Period = bitPeriod(ClkFreqMhz, BaudRate);
    localparam int CntW = $clog2(Period);
    localparam int IdxW = $clog2(DataBits);

    localparam logic [CntW-1:0] LastCnt = CntW'(Period - 1);
    localparam logic [CntW-1:0] HalfCnt = CntW'((Period / 2) - 1);
    localparam logic [IdxW-1:0] LastIdx = IdxW'(DataBits - 1);

    logic            rxMeta;
    logic            rxSync;
    rxState_t        state;
    logic [CntW-1:0] cnt;
    logic [IdxW-1:0] bitIdx;
    uartByte_t       shiftReg;
    logic            sampleBit;                 // Data sample point this cycle.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input synchronizer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rxd;
            rxSync <= rxMeta;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign sampleBit = (state == RxDataBit) && (cnt == LastCnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RxIdle;
            cnt        <= '0;
            bitIdx     <= '0;
            rxData     <= '0;
            rxValid    <= 1'b0;
            frameError <= 1'b0;
        end else begin
            rxValid    <= 1'b0;                 // Pulses last one cycle.
            frameError <= 1'b0;
            case (state)
                RxIdle: begin
                    cnt <= '0;
                    if (!rxSync) begin
                        state <= RxStartCheck;
                    end
                end
                RxStartCheck: begin
                    if (cnt == HalfCnt) begin
                        cnt    <= '0;
                        bitIdx <= '0;
                        // Still low at mid start bit, else a glitch.
                        state  <= rxSync ? RxIdle : RxDataBit;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RxDataBit: begin
                    if (cnt == LastCnt) begin
                        cnt <= '0;
                        if (bitIdx == LastIdx) begin
                            state <= RxStopBit;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RxStopBit: begin
                    if (cnt == LastCnt) begin
                        cnt   <= '0;
                        state <= RxIdle;
                        if (rxSync) begin
                            rxData  <= shiftReg;
                            rxValid <= 1'b1;
                        end else begin
                            frameError <= 1'b1;     // Old byte stays on rxData.
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= RxIdle;
                end
            endcase
        end
    end

    // Shift in from the top so the first bit ends up as the LSB.
    always_ff @(posedge clk) begin
        if (sampleBit) begin
            shiftReg <= {rxSync, shiftReg[DataBits-1:1]};
        end
    end

endmodule

// ==== rtl/uartStatePkg.sv ====
package uartStatePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmitter states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        TxIdle     = 3'd0,                      // Line high, ready high.
        TxStartBit = 3'd1,
        TxDataBit  = 3'd2,
        TxStopBit  = 3'd3,
        TxGuard    = 3'd4                       // Gap before ready rises.
    } txState_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receiver states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        RxIdle       = 3'd0,                    // Waiting for a low level.
        RxStartCheck = 3'd1,                    // Half period to mid start bit.
        RxDataBit    = 3'd2,
        RxStopBit    = 3'd3
    } rxState_t;

endpackage

// ==== rtl/uartTop.sv ====
module uartTop #(
    parameter int unsigned ClkFreqMhz = 27,
    parameter int unsigned BaudRate   = 115200
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  uartFramePkg::uartByte_t txData,
    output logic                    txd,
    output logic                    ready,
    input  logic                    rxd,
    output uartFramePkg::uartByte_t rxData,
    output logic                    rxValid,
    output logic                    frameError
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmit and receive paths are independent.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    uartTx #(
        .ClkFreqMhz(ClkFreqMhz),
        .BaudRate  (BaudRate)
    ) txInst (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .txData(txData),
        .txd   (txd),
        .ready (ready)
    );

    uartRx #(
        .ClkFreqMhz(ClkFreqMhz),
        .BaudRate  (BaudRate)
    ) rxInst (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .rxData    (rxData),
        .rxValid   (rxValid),
        .frameError(frameError)
    );

endmodule

// ==== rtl/uartTx.sv ====
module uartTx #(
    parameter int unsigned ClkFreqMhz = 27,
    parameter int unsigned BaudRate   = 115200
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  uartFramePkg::uartByte_t txData,
    output logic                   txd,
    output logic                   ready
);

    import uartFramePkg::*;
    import uartStatePkg::*;

    localparam logic [31:0] Period = bitPeriod(ClkFreqMhz, BaudRate);
    localparam int CntW = $clog2(Period);
    localparam int IdxW = $clog2(DataBits);

    localparam logic [CntW-1:0] LastCnt = CntW'(Period - 1);
    localparam logic [IdxW-1:0] LastIdx = IdxW'(DataBits - 1);

    txState_t        state;
    logic [CntW-1:0] cnt;                       // Clocks within the current bit.
    logic [IdxW-1:0] bitIdx;
    uartByte_t       dataCopy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= TxIdle;
            cnt    <= '0;
            bitIdx <= '0;
            txd    <= 1'b1;                     // Idle line is high.
            ready  <= 1'b1;
        end else begin
            case (state)
                TxIdle: begin
                    if (start) begin
                        ready <= 1'b0;
                        cnt   <= '0;
                        state <= TxStartBit;
                    end
                end
                TxStartBit: begin
                    txd <= 1'b0;
                    if (cnt == LastCnt) begin
                        cnt    <= '0;
                        bitIdx <= '0;
                        state  <= TxDataBit;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TxDataBit: begin
                    txd <= dataCopy[bitIdx];    // LSB goes out first.
                    if (cnt == LastCnt) begin
                        cnt <= '0;
                        if (bitIdx == LastIdx) begin
                            state <= TxStopBit;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TxStopBit: begin
                    txd <= 1'b1;
                    if (cnt == LastCnt) begin
                        cnt   <= '0;
                        state <= TxGuard;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TxGuard: begin
                    // One full cycle after the stop bit, then ready.
                    if (cnt != '0) begin
                        ready <= 1'b1;
                        cnt   <= '0;
                        state <= TxIdle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= TxIdle;
                    txd   <= 1'b1;
                    ready <= 1'b1;
                end
            endcase
        end
    end

    // Byte is captured only when a start is accepted.
    always_ff @(posedge clk) begin
        if (state == TxIdle && start) begin
            dataCopy <= txData;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile the UART testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module uartTopTb \
    -Mdir "$BUILD_DIR" -o uartTopTb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed."
    exit 1
fi

"./$BUILD_DIR/uartTopTb" > "$LOG" 2>&1
SIM_STATUS=$?
cat "$LOG"
if [ $SIM_STATUS -ne 0 ]; then
    echo "Simulation exited with status $SIM_STATUS."
    exit 1
fi

grep -q "Result: PASSED" "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $LOG."
    exit 1
fi

echo "Simulation passed."
exit 0

// ==== tb.f ====
rtl/uartFramePkg.sv
rtl/uartStatePkg.sv
rtl/uartTx.sv
rtl/uartRx.sv
rtl/uartTop.sv
test/uartTopTb.sv

// ==== test/uartTopTb.sv ====
module uartTopTb;

    timeunit 1ns;
    timeprecision 1ps;

    import uartFramePkg::*;

    localparam int unsigned ClkFreqMhz = 1;
    localparam int unsigned BaudRate   = 62500;
    localparam int P = int'(bitPeriod(ClkFreqMhz, BaudRate));  // 16 clocks per bit.

    logic        clk;
    logic        rst;
    logic        start;
    uartByte_t   txData;
    logic        txd;
    logic        ready;
    logic        rxd;
    uartByte_t   rxData;
    logic        rxValid;
    logic        frameError;

    logic        loopEn;                        // Route txd back into rxd.
    logic        rxDrive;
    logic [31:0] lcgState;
    int          validCount;
    int          errorCount;
    uartByte_t   seenData;                      // rxData at the last valid pulse.
    uartByte_t   lastRx;

    assign rxd = loopEn ? txd : rxDrive;

    uartTop #(
        .ClkFreqMhz(ClkFreqMhz),
        .BaudRate  (BaudRate)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .txData    (txData),
        .txd       (txd),
        .ready     (ready),
        .rxd       (rxd),
        .rxData    (rxData),
        .rxValid   (rxValid),
        .frameError(frameError)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic uartByte_t nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[23:16];                 // Upper bits are the better mixed ones.
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("** Error %s: expected 0x%h, actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic checkByte(input string name, input uartByte_t expected,
                             input uartByte_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("** Error %s: expected 0x%h, actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            abortRun($sformatf("** Error %s: expected 0x%h, actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic clearSeen();
        validCount = 0;
        errorCount = 0;
    endtask

    // One clock, sampled at the falling edge where outputs are settled.
    task automatic stepCycle();
        @(negedge clk);
        if (rxValid === 1'b1 && frameError === 1'b1) begin
            abortRun("rxValid and frameError were high in the same cycle.");
        end
        if (rxValid === 1'b1) begin
            validCount++;
            seenData = rxData;
        end
        if (frameError === 1'b1) begin
            errorCount++;
        end
    endtask

    task automatic waitResult(input string what);
        int cycles;
        cycles = 0;
        while (validCount + errorCount == 0) begin
            stepCycle();
            cycles++;
            if (cycles > 12 * P) begin
                abortRun({"Timeout: no rxValid or frameError pulse came for the ", what, "."});
            end
        end
    endtask

    task automatic waitReady(input string what);
        int cycles;
        cycles = 0;
        while (ready !== 1'b1) begin
            stepCycle();
            cycles++;
            if (cycles > 12 * P) begin
                abortRun({"Timeout: ready never rose ", what, "."});
            end
        end
    endtask

    task automatic sendByte(input uartByte_t data);
        waitReady("before a new start");
        txData = data;
        start  = 1'b1;
        stepCycle();
        start  = 1'b0;
    endtask

    task automatic quietWindow(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            checkBit("rxValid", 1'b0, rxValid);
            checkBit("frameError", 1'b0, frameError);
            checkBit("txd", 1'b1, txd);
        end
    endtask

    task automatic driveBit(input logic level);
        rxDrive = level;
        repeat (P) stepCycle();
    endtask

    task automatic driveFrame(input uartByte_t data, input logic stopLevel);
        driveBit(1'b0);
        for (int i = 0; i < DataBits; i++) begin
            driveBit(data[i]);                  // LSB first.
        end
        driveBit(stopLevel);
        rxDrive = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic resetLevels();
        checkBit("txd", 1'b1, txd);
        checkBit("ready", 1'b1, ready);
        checkBit("rxValid", 1'b0, rxValid);
        checkBit("frameError", 1'b0, frameError);
        checkByte("rxData", 8'h00, rxData);
    endtask

    task automatic txWaveform();
        uartByte_t data;
        int        cycles;
        int        fallAt;
        int        bitNum;
        logic      expected;
        data   = 8'hA5;
        loopEn = 1'b0;
        checkCount("bit period", 16, P);        // 1 MHz at 62500 baud.
        sendByte(data);
        checkBit("ready", 1'b0, ready);         // Dropped at the accepting edge.
        checkBit("txd", 1'b1, txd);             // Start bit begins one edge later.
        cycles = 0;
        fallAt = -1;
        bitNum = 0;
        while (ready !== 1'b1) begin
            stepCycle();
            cycles++;
            if (cycles > 12 * P) begin
                abortRun("Timeout: ready never rose after the transmit frame.");
            end
            if (fallAt < 0 && txd === 1'b0) begin
                fallAt = cycles;
            end
            if (fallAt >= 0 && bitNum < 10 && cycles - fallAt == bitNum * P + P / 2) begin
                if (bitNum == 0) begin
                    expected = 1'b0;
                end else if (bitNum == 9) begin
                    expected = 1'b1;
                end else begin
                    expected = data[bitNum-1];
                end
                checkBit($sformatf("txd bit %0d", bitNum), expected, txd);
                bitNum++;
            end
        end
        checkCount("txd fall cycle", 1, fallAt);
        checkCount("txd bits sampled", 10, bitNum);
        checkCount("ready latency", 10 * P + 2, cycles);
    endtask

    task automatic loopbackRandom();
        uartByte_t sent;
        loopEn = 1'b1;
        for (int i = 0; i < 16; i++) begin
            sent = nextRandom();
            clearSeen();
            sendByte(sent);
            waitResult("loopback byte");
            checkCount("frameError pulses", 0, errorCount);
            checkByte("rxData", sent, seenData);
            lastRx = sent;
        end
    endtask

    task automatic busyStart();
        uartByte_t first;
        uartByte_t second;
        first  = 8'h3C;
        second = 8'hC3;
        loopEn = 1'b1;
        clearSeen();
        sendByte(first);
        repeat (3 * P) stepCycle();             // Well inside the data bits.
        txData = second;
        start  = 1'b1;
        stepCycle();
        start  = 1'b0;
        checkBit("ready", 1'b0, ready);
        waitResult("first byte of the busy test");
        checkCount("frameError pulses", 0, errorCount);
        checkByte("rxData", first, seenData);
        lastRx = first;
        waitReady("after the busy test frame");
        checkCount("rxValid pulses", 1, validCount);
        quietWindow(11 * P);                    // A second frame would show here.
    endtask

    task automatic framingError();
        loopEn  = 1'b0;
        rxDrive = 1'b1;
        repeat (2 * P) stepCycle();
        clearSeen();
        driveFrame(~lastRx, 1'b0);
        waitResult("frame with a low stop bit");
        repeat (2 * P) stepCycle();
        checkCount("frameError pulses", 1, errorCount);
        checkCount("rxValid pulses", 0, validCount);
        checkByte("rxData", lastRx, rxData);
    endtask

    task automatic glitchReject();
        uartByte_t data;
        loopEn  = 1'b0;
        rxDrive = 1'b0;
        repeat (P / 4) stepCycle();
        rxDrive = 1'b1;
        quietWindow(12 * P);
        data = nextRandom();
        clearSeen();
        driveFrame(data, 1'b1);
        waitResult("frame after the glitch");
        checkCount("frameError pulses", 0, errorCount);
        checkByte("rxData", data, seenData);
        lastRx = data;
    endtask

    initial begin
        lcgState   = 32'd88;
        rst        = 1'b1;
        start      = 1'b0;
        txData     = '0;
        loopEn     = 1'b0;
        rxDrive    = 1'b1;
        validCount = 0;
        errorCount = 0;
        seenData   = '0;
        lastRx     = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        resetLevels();
        txWaveform();
        loopbackRandom();
        busyStart();
        framingError();
        glitchReject();
        $display("Result: PASSED");
        $finish;
    end

endmodule
